// ==== source/dmem_pkg.sv ====
package dmem_pkg;

	localparam int num_lanes	= 2;
	localparam int lane_bits	= 1;	// Enough to index num_lanes

	localparam int mem_words	= 64;
	localparam int addr_bits	= 6;	// log2 of mem_words
	localparam int data_bits	= 32;
	localparam int length_bits	= 4;	// Element count minus one

	// One memory word
	typedef logic [data_bits-1:0]	data_t;

	// Word address, arithmetic wraps at mem_words
	typedef logic [addr_bits-1:0]	addr_t;

	// Encoded as count minus one, so 1 to 16 elements
	typedef logic [length_bits-1:0]	length_t;

	typedef logic [lane_bits-1:0]	lane_t;

	typedef enum logic {
		op_store	= 1'b0,
		op_load		= 1'b1
	} op_t;

endpackage

// ==== source/access_if.sv ====
`timescale 1ns/1ns

// Granted access command, arbiter to address generator
interface access_if
	import dmem_pkg::*;
();

	logic		valid;
	op_t		op;
	addr_t		base;
	addr_t		stride;
	length_t	length;
	lane_t		lane;		// Lane that owns the command
	logic		ready;		// High while the address generator is idle

	modport arbiter (
		output	valid,
		output	op,
		output	base,
		output	stride,
		output	length,
		output	lane,
		input	ready
	);

	modport agu (
		input	valid,
		input	op,
		input	base,
		input	stride,
		input	length,
		input	lane,
		output	ready
	);

endinterface

// ==== source/bank_if.sv ====
`timescale 1ns/1ns

// One element per handshake, address generator to bank
interface bank_if
	import dmem_pkg::*;
();

	logic		valid;
	op_t		op;
	addr_t		address;
	lane_t		lane;
	logic		accept;		// Element completes on valid and accept

	modport agu (
		output	valid,
		output	op,
		output	address,
		output	lane,
		input	accept
	);

	modport bank (
		input	valid,
		input	op,
		input	address,
		input	lane,
		output	accept
	);

endinterface

// ==== source/access_arbiter.sv ====
`timescale 1ns/1ns

module access_arbiter
	import dmem_pkg::*;
(
	input	logic					clock,
	input	logic					reset,
	input	logic [num_lanes-1:0]	cmd_valid,
	input	op_t					cmd_op		[num_lanes],
	input	addr_t					cmd_base	[num_lanes],
	input	addr_t					cmd_stride	[num_lanes],
	input	length_t				cmd_length	[num_lanes],
	output	logic [num_lanes-1:0]	cmd_ready,
	access_if.arbiter				access
);

	lane_t		prio_lane;		// Lane that wins a tie
	lane_t		grant;
	logic		any_valid;
	logic		transfer;

	// Scan lanes starting at the priority lane
	always_comb begin
		lane_t	cand;
		logic	found;

		found	= 1'b0;
		grant	= prio_lane;
		for (int i = 0; i < num_lanes; i++) begin
			cand = lane_t'(prio_lane + i);	// Wraps over the lane count
			if (!found && cmd_valid[cand]) begin
				found	= 1'b1;
				grant	= cand;
			end
		end
	end

	assign any_valid	= |cmd_valid;
	assign transfer		= access.valid & access.ready;

	assign access.valid		= any_valid;
	assign access.op		= cmd_op[grant];
	assign access.base		= cmd_base[grant];
	assign access.stride	= cmd_stride[grant];
	assign access.length	= cmd_length[grant];
	assign access.lane		= grant;

	// Only the winner sees the address generator's ready
	always_comb begin
		cmd_ready = '0;
		if (any_valid) begin
			cmd_ready[grant] = access.ready;
		end
	end

	// Pointer moves past the served lane on a completed transfer
	always_ff @(posedge clock) begin
		if (reset) begin
			prio_lane <= '0;
		end else if (transfer) begin
			prio_lane <= lane_t'(grant + 1'b1);
		end
	end

endmodule

// ==== source/stride_agu.sv ====
`timescale 1ns/1ns

module stride_agu
	import dmem_pkg::*;
(
	input	logic		clock,
	input	logic		reset,
	access_if.agu		access,
	bank_if.agu			elem
);

	logic		armed;			// Low only in the cycle after reset
	logic		busy;
	addr_t		cur_addr;
	addr_t		stride;
	length_t	remaining;		// Elements left after the current one
	op_t		op;
	lane_t		lane;

	logic		take_cmd;
	logic		step;
	logic		last_elem;

	assign access.ready	= armed & ~busy;

	assign take_cmd		= access.valid & access.ready;
	assign step			= elem.valid & elem.accept;
	assign last_elem	= (remaining == '0);

	assign elem.valid	= busy;
	assign elem.op		= op;
	assign elem.address	= cur_addr;
	assign elem.lane	= lane;

	always_ff @(posedge clock) begin
		if (reset) begin
			armed <= 1'b0;
		end else begin
			armed <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
		end else if (take_cmd) begin
			busy <= 1'b1;
		end else if (step && last_elem) begin
			busy <= 1'b0;		// Idle again on the next cycle
		end
	end

	// Command fields and the walking address
	always_ff @(posedge clock) begin
		if (take_cmd) begin
			cur_addr	<= access.base;
			stride		<= access.stride;
			remaining	<= access.length;
			op			<= access.op;
			lane		<= access.lane;
		end else if (step) begin
			cur_addr	<= cur_addr + stride;	// Wraps at mem_words
			remaining	<= remaining - 1'b1;
		end
	end

endmodule

// ==== source/dmem_bank.sv ====
`timescale 1ns/1ns

module dmem_bank
	import dmem_pkg::*;
(
	input	logic					clock,
	input	logic					reset,
	bank_if.bank					elem,
	input	logic [num_lanes-1:0]	st_valid,
	input	data_t					st_data		[num_lanes],
	output	logic [num_lanes-1:0]	st_ready,
	output	logic [num_lanes-1:0]	ld_valid,
	output	data_t					ld_data		[num_lanes],
	input	logic [num_lanes-1:0]	ld_ready
);

	data_t		mem [mem_words];

	logic		out_valid;		// Load output register is full
	lane_t		out_lane;
	data_t		out_data;

	logic		is_store;
	logic		is_load;
	logic		drain;
	logic		store_fire;
	logic		load_fire;

	assign is_store	= elem.valid & (elem.op == op_store);
	assign is_load	= elem.valid & (elem.op == op_load);

	// Output register leaves this cycle
	assign drain	= out_valid & ld_ready[out_lane];

	always_comb begin
		if (elem.op == op_store) begin
			elem.accept = st_valid[elem.lane];
		end else begin
			elem.accept = ~out_valid | drain;
		end
	end

	assign store_fire	= is_store & elem.accept;
	assign load_fire	= is_load & elem.accept;

	// Store data is only taken from the owning lane
	always_comb begin
		st_ready = '0;
		if (is_store) begin
			st_ready[elem.lane] = 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (store_fire) begin
			mem[elem.address] <= st_data[elem.lane];
		end
	end

	always_ff @(posedge clock) begin
		if (load_fire) begin
			out_data	<= mem[elem.address];
			out_lane	<= elem.lane;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (load_fire) begin
			out_valid <= 1'b1;		// Refill may overlap a drain
		end else if (drain) begin
			out_valid <= 1'b0;
		end
	end

	// Lanes that do not own the register see zero
	always_comb begin
		for (int l = 0; l < num_lanes; l++) begin
			ld_valid[l]	= out_valid && (out_lane == lane_t'(l));
			ld_data[l]	= (out_lane == lane_t'(l)) ? out_data : '0;
		end
	end

endmodule

// ==== source/dmem_top.sv ====
`timescale 1ns/1ns

module dmem_top
	import dmem_pkg::*;
(
	input	logic					clock,
	input	logic					reset,

	input	logic [num_lanes-1:0]	cmd_valid,
	input	op_t					cmd_op		[num_lanes],
	input	addr_t					cmd_base	[num_lanes],
	input	addr_t					cmd_stride	[num_lanes],
	input	length_t				cmd_length	[num_lanes],
	output	logic [num_lanes-1:0]	cmd_ready,

	input	logic [num_lanes-1:0]	st_valid,
	input	data_t					st_data		[num_lanes],
	output	logic [num_lanes-1:0]	st_ready,

	output	logic [num_lanes-1:0]	ld_valid,
	output	data_t					ld_data		[num_lanes],
	input	logic [num_lanes-1:0]	ld_ready
);

	access_if	access ();
	bank_if		elem ();

	// One command at a time goes through
	access_arbiter access_arbiter (
		.clock			(clock),
		.reset			(reset),
		.cmd_valid		(cmd_valid),
		.cmd_op			(cmd_op),
		.cmd_base		(cmd_base),
		.cmd_stride		(cmd_stride),
		.cmd_length		(cmd_length),
		.cmd_ready		(cmd_ready),
		.access			(access.arbiter)
	);

	stride_agu stride_agu (
		.clock			(clock),
		.reset			(reset),
		.access			(access.agu),
		.elem			(elem.agu)
	);

	// Storage plus the registered load return
	dmem_bank dmem_bank (
		.clock			(clock),
		.reset			(reset),
		.elem			(elem.bank),
		.st_valid		(st_valid),
		.st_data		(st_data),
		.st_ready		(st_ready),
		.ld_valid		(ld_valid),
		.ld_data		(ld_data),
		.ld_ready		(ld_ready)
	);

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock (
	output	logic	clock
);

	localparam int half_period = 10;	// 20 ns period

	initial begin
		clock = 1'b0;
		forever #(half_period) clock = ~clock;
	end

endmodule

// ==== test/dmem_props.sv ====
`timescale 1ns/1ns

module dmem_props
	import dmem_pkg::*;
(
	input	logic					clock,
	input	logic					reset,
	input	logic [num_lanes-1:0]	cmd_ready,
	input	logic [num_lanes-1:0]	st_ready,
	input	logic [num_lanes-1:0]	ld_valid,
	input	logic [num_lanes-1:0]	ld_ready,
	input	data_t					ld_data		[num_lanes]
);

	int		failures = 0;

	single_grant: assert property (@(posedge clock) $onehot0(cmd_ready))
		else begin
			failures++;
			$error("cmd_ready is high for more than one lane");
		end

	single_store_lane: assert property (@(posedge clock) $onehot0(st_ready))
		else begin
			failures++;
			$error("st_ready is high for more than one lane");
		end

	// First cycle out of reset
	load_idle_after_reset: assert property (@(posedge clock) $fell(reset) |-> (ld_valid == '0))
		else begin
			failures++;
			$error("ld_valid is high in the cycle after reset");
		end

	for (genvar l = 0; l < num_lanes; l++) begin : lane
		load_hold: assert property (@(posedge clock) disable iff (reset)
			(ld_valid[l] && !ld_ready[l]) |=> (ld_valid[l] && $stable(ld_data[l])))
			else begin
				failures++;
				$error("lane %0d load output dropped or changed before ld_ready", l);
			end
	end

endmodule

bind dmem_top dmem_props props (
	.clock		(clock),
	.reset		(reset),
	.cmd_ready	(cmd_ready),
	.st_ready	(st_ready),
	.ld_valid	(ld_valid),
	.ld_ready	(ld_ready),
	.ld_data	(ld_data)
);

// ==== test/dmem_tb.sv ====
`timescale 1ns/1ns

module dmem_tb
	import dmem_pkg::*;
();

	localparam int total_cmds	= 54;
	localparam int watchdog_ns	= (total_cmds * 16 * 40 + 2000) * 20;	// Longest lengths assumed

	logic					clock;
	logic					reset;
	logic [num_lanes-1:0]	cmd_valid;
	op_t					cmd_op		[num_lanes];
	addr_t					cmd_base	[num_lanes];
	addr_t					cmd_stride	[num_lanes];
	length_t				cmd_length	[num_lanes];
	logic [num_lanes-1:0]	cmd_ready;
	logic [num_lanes-1:0]	st_valid;
	data_t					st_data		[num_lanes];
	logic [num_lanes-1:0]	st_ready;
	logic [num_lanes-1:0]	ld_valid;
	data_t					ld_data		[num_lanes];
	logic [num_lanes-1:0]	ld_ready;

	data_t	model [mem_words];
	int		checks;
	int		errors;
	int		test_checks;
	int		test_errors;
	int		last_lane;

	tb_clock clock_gen (.clock(clock));

	dmem_top dut (
		.clock(clock), .reset(reset),
		.cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_base(cmd_base),
		.cmd_stride(cmd_stride), .cmd_length(cmd_length), .cmd_ready(cmd_ready),
		.st_valid(st_valid), .st_data(st_data), .st_ready(st_ready),
		.ld_valid(ld_valid), .ld_data(ld_data), .ld_ready(ld_ready)
	);

	// One command on one lane, with its store or load stream
	task automatic run_cmd(input int l, input op_t op, input addr_t base, input addr_t stride,
			input length_t len, input bit gaps);
		data_t	words [$];
		data_t	expect_q [$];
		addr_t	a;
		int		n;
		n = int'(len) + 1;
		for (int i = 0; i < n; i++) begin
			words.push_back($urandom);
		end
		@(negedge clock);
		cmd_valid[l]	= 1'b1;
		cmd_op[l]		= op;
		cmd_base[l]		= base;
		cmd_stride[l]	= stride;
		cmd_length[l]	= len;
		@(posedge clock);
		while (!cmd_ready[l]) @(posedge clock);
		for (int i = 0; i < n; i++) begin
			a = addr_t'(int'(base) + i * int'(stride));	// Modulo 64
			if (op == op_store) begin
				model[a] = words[i];
			end else begin
				expect_q.push_back(model[a]);
			end
		end
		@(negedge clock);
		cmd_valid[l] = 1'b0;
		if (op == op_store) begin
			foreach (words[i]) begin
				while (gaps && $urandom_range(0, 2) == 0) begin
					st_valid[l] = 1'b0;
					@(negedge clock);
				end
				st_valid[l]	= 1'b1;
				st_data[l]	= words[i];
				@(posedge clock);
				while (!st_ready[l]) @(posedge clock);
				@(negedge clock);
			end
			st_valid[l] = 1'b0;
		end
		while (expect_q.size() > 0) begin
			ld_ready[l] = gaps ? 1'($urandom_range(0, 1)) : 1'b1;
			@(posedge clock);
			if (ld_valid[l] && ld_ready[l]) begin
				checks++;
				assert (ld_data[l] == expect_q[0]) else begin
					errors++;
					$display("FAIL %0t: lane %0d load returned %h, expected %h",
						$time, l, ld_data[l], expect_q[0]);
				end
				void'(expect_q.pop_front());
			end
			@(negedge clock);
		end
		ld_ready[l] = 1'b0;
		if (op == op_load) begin
			checks++;
			assert (!ld_valid[l]) else begin
				errors++;
				$display("Lane %0d got a load element beyond the end of its command", l);
			end
		end
	endtask

	task automatic random_cmd(input int l, input bit gaps);
		op_t	op;
		op = ($urandom_range(0, 1) == 1) ? op_load : op_store;
		run_cmd(l, op, addr_t'($urandom), addr_t'($urandom_range(1, 63)),
			length_t'($urandom), gaps);
	endtask

	// Store port must stay closed once a store command has all its words
	task automatic check_no_extra_store(input int l);
		@(negedge clock);
		st_valid[l]	= 1'b1;
		st_data[l]	= $urandom;
		repeat (3) begin
			@(posedge clock);
			checks++;
			assert (!st_ready[l]) else begin
				errors++;
				$display("Lane %0d store port took a word after the command ended", l);
			end
		end
		@(negedge clock);
		st_valid[l] = 1'b0;
	endtask

	task automatic finish_test(input string name);
		$display("%s done: %0d checks, %0d errors", name, checks - test_checks,
			errors - test_errors);
		test_checks	= checks;
		test_errors	= errors;
	endtask

	// Round-robin order while both lanes wait
	always @(posedge clock) begin
		if (!reset) begin
			for (int l = 0; l < num_lanes; l++) begin
				if (cmd_valid[l] && cmd_ready[l]) begin
					if (&cmd_valid) begin
						checks++;
						assert (l != last_lane) else begin
							errors++;
							$display("FAIL %0t: lane %0d granted twice while both lanes waited",
								$time, l);
						end
					end
					last_lane = l;
				end
			end
		end
	end

	initial begin
		#(watchdog_ns);
		$display("Run timed out after %0d ns before all commands completed", watchdog_ns);
		$display("Test failed");
		$finish;
	end

	initial begin
		addr_t		base;
		addr_t		stride;
		length_t	len;
		void'($urandom(32'hb1533e40));
		reset		= 1'b1;
		cmd_valid	= '0;
		st_valid	= '0;
		ld_ready	= '0;
		checks		= 0;
		errors		= 0;
		test_checks	= 0;
		test_errors	= 0;
		last_lane	= num_lanes - 1;	// Pointer starts at lane 0
		for (int l = 0; l < num_lanes; l++) begin
			cmd_op[l]		= op_store;
			cmd_base[l]		= '0;
			cmd_stride[l]	= '0;
			cmd_length[l]	= '0;
			st_data[l]		= '0;
		end
		repeat (5) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		for (int b = 0; b < mem_words; b += 16) begin
			run_cmd(0, op_store, addr_t'(b), addr_t'(1), length_t'(15), 1'b0);
		end
		finish_test("memory fill");

		base = addr_t'($urandom);
		run_cmd(0, op_store, base, addr_t'(1), length_t'(7), 1'b0);
		run_cmd(0, op_load, base, addr_t'(1), length_t'(7), 1'b0);
		finish_test("single store and readback");

		repeat (6) begin
			base	= addr_t'(56 + $urandom_range(0, 7));	// Walks past 63
			stride	= addr_t'($urandom_range(1, 63));
			len		= length_t'($urandom_range(8, 15));
			run_cmd(1, op_store, base, stride, len, 1'b0);
			run_cmd(1, op_load, base, stride, len, 1'b0);
		end
		finish_test("strided wrap");

		fork
			repeat (10) random_cmd(0, 1'($urandom_range(0, 1)));
			repeat (10) random_cmd(1, 1'($urandom_range(0, 1)));
		join
		finish_test("two competing lanes");

		repeat (4) begin
			base	= addr_t'($urandom);
			stride	= addr_t'($urandom_range(1, 63));
			len		= length_t'($urandom);
			run_cmd(0, op_store, base, stride, len, 1'b0);
			run_cmd(0, op_load, base, stride, len, 1'b1);
		end
		finish_test("load back-pressure");

		repeat (4) begin
			base	= addr_t'($urandom);
			stride	= addr_t'($urandom_range(1, 63));
			len		= length_t'($urandom);
			run_cmd(1, op_store, base, stride, len, 1'b1);
			check_no_extra_store(1);
			run_cmd(1, op_load, base, stride, len, 1'b0);
		end
		finish_test("store gaps");

		repeat (4) @(posedge clock);
		$display("Checks passed %0d, failed %0d, assertion failures %0d", checks - errors,
			errors, dut.props.failures);
		if (errors == 0 && dut.props.failures == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== compile.f ====
source/dmem_pkg.sv
source/access_if.sv
source/bank_if.sv
source/access_arbiter.sv
source/stride_agu.sv
source/dmem_bank.sv
source/dmem_top.sv
test/tb_clock.sv
test/dmem_props.sv
test/dmem_tb.sv

// ==== run.sh ====
#!/bin/bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module dmem_tb -f compile.f -o Vdmem_tb

./obj_dir/Vdmem_tb 2>&1 | tee sim.log

if grep -q "Test failed" sim.log; then
	exit 1
fi
exit 0
